// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_barrett_redc
FILELIST  ?= barrett_redc.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS)); echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: barrett_redc.f
+incdir+src
src/redc_data_pkg.sv
src/redc_ctrl_pkg.sv
src/mult_64x64.sv
src/word_acc.sv
src/operand_store.sv
src/redc_datapath.sv
src/redc_ctrl.sv
src/result_writer.sv
src/barrett_redc_top.sv
tb/barrett_redc_chk.sv
tb/tb_barrett_redc.sv

// File: src/barrett_redc_top.sv
`timescale 1ns/10ps

module barrett_redc_top (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    in_valid,
	input  redc_data_pkg::op_pair_t in_pair,
	input  logic                    sign_strobe,
	input  logic                    sign_in,
	output redc_data_pkg::res_wr_t  res,
	output logic                    red_done,
	output logic                    burst_done
);

	redc_ctrl_pkg::ctrl_bus_t ctrl;
	redc_data_pkg::word_t     rd_word;
	logic loaded, mul_done, quot_ready, sub_last, borrow, out_last;
	logic emit, red_end;

	redc_ctrl u_ctrl (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.loaded     (loaded),
		.mul_done   (mul_done),
		.quot_ready (quot_ready),
		.sub_last   (sub_last),
		.borrow     (borrow),
		.out_last   (out_last),
		.ctrl       (ctrl),
		.emit       (emit),
		.red_end    (red_end)
	);

	redc_datapath u_datapath (
		.clk        (clk),
		.rst        (rst),
		.ctrl       (ctrl),
		.in_pair    (in_pair),
		.loaded     (loaded),
		.mul_done   (mul_done),
		.quot_ready (quot_ready),
		.sub_last   (sub_last),
		.borrow     (borrow),
		.out_last   (out_last),
		.rd_word    (rd_word)
	);

	result_writer u_writer (
		.clk         (clk),
		.rst         (rst),
		.sign_strobe (sign_strobe),
		.sign_in     (sign_in),
		.emit        (emit),
		.red_end     (red_end),
		.rd_word     (rd_word),
		.res         (res),
		.red_done    (red_done),
		.burst_done  (burst_done)
	);

endmodule

// File: src/mult_64x64.sv
`timescale 1ns/10ps
`include "redc_consts.svh"

module mult_64x64 (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start,
	input  redc_data_pkg::mul_in_t a,
	input  redc_data_pkg::mul_in_t b,
	output redc_data_pkg::prod_t   p,
	output logic                  done
);

	logic [63:0] pp_ll, pp_lh, pp_hl, pp_hh;   // stage 1
	logic [64:0] mid;                          // stage 2
	logic [127:0] outer;
	logic [`REDC_MUL_LAT-1:0] vld;

	always_ff @(posedge clk) begin
		pp_ll <= a[31:0] * b[31:0];
		pp_lh <= a[31:0] * b[63:32];
		pp_hl <= a[63:32] * b[31:0];
		pp_hh <= a[63:32] * b[63:32];
		mid   <= {1'b0, pp_lh} + {1'b0, pp_hl};
		outer <= {pp_hh, pp_ll};
		p     <= outer + {31'd0, mid, 32'd0};  // stage 3
	end

	// done travels beside the data
	always_ff @(posedge clk) begin
		if (rst) begin
			vld <= '0;
		end else begin
			vld <= {vld[`REDC_MUL_LAT-2:0], start};
		end
	end

	assign done = vld[`REDC_MUL_LAT-1];

endmodule

// File: src/operand_store.sv
`timescale 1ns/10ps
`include "redc_consts.svh"

module operand_store (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 we,
	input  redc_data_pkg::word_t din,
	input  logic                 wa_clr,
	input  logic                 wa_inc,
	input  logic                 ra_clr,
	input  logic                 ra_inc,
	input  logic                 ra_dec,
	output redc_data_pkg::word_t dout,
	output logic [2:0]           waddr,
	output logic [2:0]           raddr
);

	redc_data_pkg::word_t mem [`REDC_OP_WORDS];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr[1:0]] <= din;
		end
	end

	assign dout = mem[raddr[1:0]];  // distributed ram, async read

	//////////////////////////////////////////////////
	// address counters
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst || wa_clr) begin
			waddr <= '0;
		end else if (wa_inc) begin
			waddr <= waddr + 3'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || ra_clr) begin
			raddr <= '0;
		end else if (ra_inc) begin
			raddr <= raddr + 3'd1;
		end else if (ra_dec) begin
			raddr <= raddr - 3'd1;
		end
	end

endmodule

// File: src/redc_consts.svh
`ifndef REDC_CONSTS_SVH
`define REDC_CONSTS_SVH

`define REDC_WORD_W     59
`define REDC_OP_WORDS   4
`define REDC_RES_WORDS  4

// modulus q = (2^181 - 2) / 3, least significant word first
`define REDC_Q_W0       59'd192153584101141162
`define REDC_Q_W1       59'd384307168202282325
`define REDC_Q_W2       59'd192153584101141162
`define REDC_Q_W3       59'd5

// floor(2^216 / q) = 3 * 2^35
`define REDC_M          64'd103079215104
`define REDC_Q_SHIFT    39      // 216 - 3*59, start bit inside column 3

`define REDC_BASE_LO    11'd1024
`define REDC_BASE_HI    11'd1045
`define REDC_CORE_EVEN  3'd3
`define REDC_CORE_ODD   3'd4

`define REDC_MUL_LAT    3

`endif

// File: src/redc_ctrl.sv
`timescale 1ns/10ps

module redc_ctrl (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     in_valid,
	input  logic                     loaded,
	input  logic                     mul_done,
	input  logic                     quot_ready,
	input  logic                     sub_last,
	input  logic                     borrow,
	input  logic                     out_last,
	output redc_ctrl_pkg::ctrl_bus_t ctrl,
	output logic                     emit,
	output logic                     red_end
);

	redc_ctrl_pkg::redc_state_t state, next_state;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= redc_ctrl_pkg::ST_IDLE;
		end else begin
			state <= next_state;
		end
	end

	//////////////////////////////////////////////////
	// next state
	//////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			redc_ctrl_pkg::ST_IDLE:      next_state = redc_ctrl_pkg::ST_LOAD_WAIT;
			redc_ctrl_pkg::ST_LOAD_WAIT: begin
				if (loaded) begin
					next_state = redc_ctrl_pkg::ST_QX_CLR;
				end else if (in_valid) begin
					next_state = redc_ctrl_pkg::ST_LOAD_LO;
				end
			end
			redc_ctrl_pkg::ST_LOAD_LO:   next_state = redc_ctrl_pkg::ST_LOAD_HI;
			redc_ctrl_pkg::ST_LOAD_HI:   next_state = redc_ctrl_pkg::ST_LOAD_WAIT;
			redc_ctrl_pkg::ST_QX_CLR:    next_state = redc_ctrl_pkg::ST_QX_MUL;
			redc_ctrl_pkg::ST_QX_MUL:    next_state = redc_ctrl_pkg::ST_QX_WAIT;
			redc_ctrl_pkg::ST_QX_WAIT:   if (mul_done) next_state = redc_ctrl_pkg::ST_QX_ACC;
			redc_ctrl_pkg::ST_QX_ACC:    next_state = quot_ready ? redc_ctrl_pkg::ST_SQ_CLR
				: redc_ctrl_pkg::ST_QX_MUL;
			redc_ctrl_pkg::ST_SQ_CLR:    next_state = redc_ctrl_pkg::ST_SQ_MUL;
			redc_ctrl_pkg::ST_SQ_MUL:    next_state = redc_ctrl_pkg::ST_SQ_WAIT;
			redc_ctrl_pkg::ST_SQ_WAIT:   if (mul_done) next_state = redc_ctrl_pkg::ST_SQ_SUB;
			redc_ctrl_pkg::ST_SQ_SUB:    next_state = redc_ctrl_pkg::ST_SQ_WR;
			redc_ctrl_pkg::ST_SQ_WR:     next_state = sub_last ? redc_ctrl_pkg::ST_CT_CLR
				: redc_ctrl_pkg::ST_SQ_MUL;
			redc_ctrl_pkg::ST_CT_CLR:    next_state = redc_ctrl_pkg::ST_CT_SUB;
			redc_ctrl_pkg::ST_CT_SUB:    if (sub_last) next_state = redc_ctrl_pkg::ST_CT_CHK;
			// a borrow means r < q already
			redc_ctrl_pkg::ST_CT_CHK:    next_state = borrow ? redc_ctrl_pkg::ST_OUT_CLR
				: redc_ctrl_pkg::ST_CW_CLR;
			redc_ctrl_pkg::ST_CW_CLR:    next_state = redc_ctrl_pkg::ST_CW_SUB;
			redc_ctrl_pkg::ST_CW_SUB:    next_state = redc_ctrl_pkg::ST_CW_WR;
			redc_ctrl_pkg::ST_CW_WR:     next_state = sub_last ? redc_ctrl_pkg::ST_CT_CLR
				: redc_ctrl_pkg::ST_CW_SUB;
			redc_ctrl_pkg::ST_OUT_CLR:   next_state = redc_ctrl_pkg::ST_OUT_RD;
			redc_ctrl_pkg::ST_OUT_RD:    if (out_last) next_state = redc_ctrl_pkg::ST_END;
			redc_ctrl_pkg::ST_END:       next_state = redc_ctrl_pkg::ST_IDLE;
			default:                     next_state = redc_ctrl_pkg::ST_IDLE;
		endcase
	end

	//////////////////////////////////////////////////
	// moore outputs
	//////////////////////////////////////////////////

	always_comb begin
		ctrl = '0;
		ctrl.op_sel = redc_ctrl_pkg::SEL_M_X;
		case (state)
			redc_ctrl_pkg::ST_IDLE: begin
				ctrl.wa_clr     = 1'b1;
				ctrl.ra_clr     = 1'b1;
				ctrl.acc_clr    = 1'b1;
				ctrl.borrow_clr = 1'b1;
				ctrl.op_sel     = redc_ctrl_pkg::SEL_IN_LO;
			end
			redc_ctrl_pkg::ST_LOAD_WAIT: ctrl.op_sel = redc_ctrl_pkg::SEL_IN_LO;
			redc_ctrl_pkg::ST_LOAD_LO, redc_ctrl_pkg::ST_LOAD_HI: begin
				ctrl.we     = 1'b1;
				ctrl.wa_inc = 1'b1;
				ctrl.op_sel = (state == redc_ctrl_pkg::ST_LOAD_LO) ?
					redc_ctrl_pkg::SEL_IN_LO : redc_ctrl_pkg::SEL_IN_HI;
			end
			redc_ctrl_pkg::ST_QX_CLR: begin
				ctrl.ra_clr  = 1'b1;
				ctrl.acc_clr = 1'b1;
			end
			redc_ctrl_pkg::ST_QX_MUL: ctrl.mul_start = 1'b1;
			redc_ctrl_pkg::ST_QX_ACC: begin
				ctrl.quot_lo = 1'b1;   // datapath picks the column
				ctrl.quot_hi = 1'b1;
				ctrl.ra_inc  = 1'b1;
			end
			redc_ctrl_pkg::ST_SQ_CLR: begin
				ctrl.ra_clr     = 1'b1;
				ctrl.wa_clr     = 1'b1;
				ctrl.acc_clr    = 1'b1;
				ctrl.borrow_clr = 1'b1;
				ctrl.op_sel     = redc_ctrl_pkg::SEL_QUOT_Q;
			end
			redc_ctrl_pkg::ST_SQ_MUL: begin
				ctrl.mul_start = 1'b1;
				ctrl.op_sel    = redc_ctrl_pkg::SEL_QUOT_Q;
			end
			redc_ctrl_pkg::ST_SQ_WAIT: ctrl.op_sel = redc_ctrl_pkg::SEL_QUOT_Q;
			redc_ctrl_pkg::ST_SQ_SUB: begin
				ctrl.sub_en = 1'b1;
				ctrl.ra_inc = 1'b1;
				ctrl.op_sel = redc_ctrl_pkg::SEL_QUOT_Q;
			end
			redc_ctrl_pkg::ST_SQ_WR: begin
				ctrl.we     = 1'b1;
				ctrl.wa_inc = 1'b1;
				ctrl.op_sel = redc_ctrl_pkg::SEL_QUOT_Q;
			end
			redc_ctrl_pkg::ST_CT_CLR, redc_ctrl_pkg::ST_CW_CLR: begin
				ctrl.ra_clr     = 1'b1;
				ctrl.wa_clr     = 1'b1;
				ctrl.borrow_clr = 1'b1;
			end
			redc_ctrl_pkg::ST_CT_SUB: begin
				ctrl.sub_en = 1'b1;
				ctrl.ra_inc = 1'b1;
				ctrl.wa_inc = 1'b1;    // counts words only
			end
			redc_ctrl_pkg::ST_CW_SUB: begin
				ctrl.sub_en = 1'b1;
				ctrl.ra_inc = 1'b1;
			end
			redc_ctrl_pkg::ST_CW_WR: begin
				ctrl.we     = 1'b1;
				ctrl.wa_inc = 1'b1;
			end
			redc_ctrl_pkg::ST_OUT_CLR: ctrl.ra_clr = 1'b1;
			redc_ctrl_pkg::ST_OUT_RD: begin
				ctrl.emit   = 1'b1;
				ctrl.ra_inc = 1'b1;
			end
			default: ;
		endcase
	end

	assign emit    = ctrl.emit;
	assign red_end = (state == redc_ctrl_pkg::ST_END);

endmodule

// File: src/redc_ctrl_pkg.sv
package redc_ctrl_pkg;

	typedef enum logic [4:0] {
		ST_IDLE,
		ST_LOAD_WAIT,
		ST_LOAD_LO,
		ST_LOAD_HI,
		ST_QX_CLR,      // quotient estimate, m * x
		ST_QX_MUL,
		ST_QX_WAIT,
		ST_QX_ACC,
		ST_SQ_CLR,      // r = x - quot * q
		ST_SQ_MUL,
		ST_SQ_WAIT,
		ST_SQ_SUB,
		ST_SQ_WR,
		ST_CT_CLR,      // trial r - q, no write
		ST_CT_SUB,
		ST_CT_CHK,
		ST_CW_CLR,      // r = r - q, written back
		ST_CW_SUB,
		ST_CW_WR,
		ST_OUT_CLR,
		ST_OUT_RD,
		ST_END
	} redc_state_t;

	// operand select: ram input source and multiplier pair
	typedef enum logic [1:0] {
		SEL_IN_LO,
		SEL_IN_HI,
		SEL_M_X,
		SEL_QUOT_Q
	} op_sel_t;

	typedef struct packed {
		logic    we;
		logic    wa_clr;
		logic    wa_inc;
		logic    ra_clr;
		logic    ra_inc;
		logic    ra_dec;
		logic    mul_start;
		logic    acc_clr;
		op_sel_t op_sel;
		logic    sub_en;
		logic    borrow_clr;
		logic    quot_lo;
		logic    quot_hi;
		logic    emit;
	} ctrl_bus_t;

endpackage

// File: src/redc_data_pkg.sv
`include "redc_consts.svh"

package redc_data_pkg;

	typedef logic [`REDC_WORD_W-1:0] word_t;
	typedef logic [63:0] mul_in_t;
	typedef logic [127:0] prod_t;

	// one load strobe carries two operand words
	typedef struct packed {
		word_t hi;
		word_t lo;
	} op_pair_t;

	// one write into the banked result memory
	typedef struct packed {
		logic        we;
		logic [10:0] addr;
		logic [2:0]  core;
		word_t       data;
		logic        sign;
	} res_wr_t;

endpackage

// File: src/redc_datapath.sv
`timescale 1ns/10ps
`include "redc_consts.svh"

module redc_datapath (
	input  logic                     clk,
	input  logic                     rst,
	input  redc_ctrl_pkg::ctrl_bus_t ctrl,
	input  redc_data_pkg::op_pair_t  in_pair,
	output logic                     loaded,
	output logic                     mul_done,
	output logic                     quot_ready,
	output logic                     sub_last,
	output logic                     borrow,
	output logic                     out_last,
	output redc_data_pkg::word_t     rd_word
);

	localparam int QLO_W = `REDC_WORD_W - `REDC_Q_SHIFT;  // quotient bits from column 3

	redc_data_pkg::op_pair_t pair_q;
	redc_data_pkg::word_t    din, acc_word, q_word, diff_q;
	redc_data_pkg::mul_in_t  mul_a, mul_b;
	redc_data_pkg::prod_t    prod;
	logic [`REDC_WORD_W:0]   sub_full;
	logic [63:0]             quot;
	logic [2:0]              waddr, raddr;
	logic                    word_ready;
	logic                    use_quot;

	assign use_quot = (ctrl.op_sel == redc_ctrl_pkg::SEL_QUOT_Q);

	// hold the pair while waiting, the input strobe lasts one cycle
	always_ff @(posedge clk) begin
		if (ctrl.op_sel == redc_ctrl_pkg::SEL_IN_LO && !ctrl.we) begin
			pair_q <= in_pair;
		end
	end

	always_comb begin
		case (ctrl.op_sel)
			redc_ctrl_pkg::SEL_IN_LO: din = pair_q.lo;
			redc_ctrl_pkg::SEL_IN_HI: din = pair_q.hi;
			default:                  din = diff_q;  // write back r
		endcase
	end

	operand_store u_store (
		.clk    (clk),
		.rst    (rst),
		.we     (ctrl.we),
		.din    (din),
		.wa_clr (ctrl.wa_clr),
		.wa_inc (ctrl.wa_inc),
		.ra_clr (ctrl.ra_clr),
		.ra_inc (ctrl.ra_inc),
		.ra_dec (ctrl.ra_dec),
		.dout   (rd_word),
		.waddr  (waddr),
		.raddr  (raddr)
	);

	always_comb begin
		case (raddr[1:0])
			2'd0:    q_word = `REDC_Q_W0;
			2'd1:    q_word = `REDC_Q_W1;
			2'd2:    q_word = `REDC_Q_W2;
			default: q_word = `REDC_Q_W3;
		endcase
	end

	//////////////////////////////////////////////////
	// multiplier and column accumulator
	//////////////////////////////////////////////////

	assign mul_a = use_quot ? quot : `REDC_M;
	// a zero product past the top word flushes the last column
	assign mul_b = use_quot ? {5'd0, q_word} :
		(raddr == `REDC_OP_WORDS) ? 64'd0 : {5'd0, rd_word};

	mult_64x64 u_mult (
		.clk   (clk),
		.rst   (rst),
		.start (ctrl.mul_start),
		.a     (mul_a),
		.b     (mul_b),
		.p     (prod),
		.done  (mul_done)
	);

	word_acc u_acc (
		.clk        (clk),
		.rst        (rst),
		.clear      (ctrl.acc_clr),
		.add_en     (mul_done),
		.prod       (prod),
		.word       (acc_word),
		.word_ready (word_ready)
	);

	always_ff @(posedge clk) begin
		if (ctrl.quot_lo && word_ready && raddr == 3'd3) begin
			quot[QLO_W-1:0] <= acc_word[`REDC_WORD_W-1:`REDC_Q_SHIFT];
		end
		if (ctrl.quot_hi && word_ready && raddr == `REDC_OP_WORDS) begin
			quot[63:QLO_W] <= acc_word[63-QLO_W:0];
		end
	end

	//////////////////////////////////////////////////
	// borrow chain subtractor
	//////////////////////////////////////////////////

	assign sub_full = {1'b0, rd_word} - {1'b0, (use_quot ? acc_word : q_word)}
		- {{`REDC_WORD_W{1'b0}}, borrow};

	always_ff @(posedge clk) begin
		if (ctrl.sub_en) begin
			diff_q <= sub_full[`REDC_WORD_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (rst || ctrl.borrow_clr) begin
			borrow <= 1'b0;
		end else if (ctrl.sub_en) begin
			borrow <= sub_full[`REDC_WORD_W];
		end
	end

	// status flags
	assign loaded     = (waddr == `REDC_OP_WORDS);
	assign quot_ready = word_ready && (raddr == `REDC_OP_WORDS);
	assign sub_last   = (waddr == `REDC_OP_WORDS - 1);
	assign out_last   = (raddr == `REDC_RES_WORDS - 1);  // next step passes the last word

endmodule

// File: src/result_writer.sv
`timescale 1ns/10ps
`include "redc_consts.svh"

module result_writer (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   sign_strobe,
	input  logic                   sign_in,
	input  logic                   emit,
	input  logic                   red_end,
	input  redc_data_pkg::word_t   rd_word,
	output redc_data_pkg::res_wr_t res,
	output logic                   red_done,
	output logic                   burst_done
);

	logic                 sign_mem [4];
	logic [1:0]           wr_ptr, rd_ptr;
	logic [1:0]           red_cnt;
	logic                 we_q, sign_q;
	logic [10:0]          addr_q;
	logic [2:0]           core_q;
	redc_data_pkg::word_t data_q;

	//////////////////////////////////////////////////
	// sign fifo, one entry per reduction
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (sign_strobe) begin
			sign_mem[wr_ptr] <= sign_in;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (sign_strobe) wr_ptr <= wr_ptr + 2'd1;
			if (red_end) rd_ptr <= rd_ptr + 2'd1;   // pop after the last write
		end
	end

	// write port
	always_ff @(posedge clk) begin
		if (emit) begin
			data_q <= rd_word;
			sign_q <= sign_mem[rd_ptr];
			core_q <= red_cnt[0] ? `REDC_CORE_ODD : `REDC_CORE_EVEN;
			if (!we_q) begin
				addr_q <= (red_cnt < 2'd2) ? `REDC_BASE_LO : `REDC_BASE_HI;
			end else begin
				addr_q <= addr_q + 11'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			we_q       <= 1'b0;
			red_cnt    <= '0;
			red_done   <= 1'b0;
			burst_done <= 1'b0;
		end else begin
			we_q       <= emit;
			red_done   <= red_end;
			burst_done <= red_end && (red_cnt == 2'd3);
			if (red_end) red_cnt <= red_cnt + 2'd1;
		end
	end

	assign res = '{we: we_q, addr: addr_q, core: core_q, data: data_q, sign: sign_q};

endmodule

// File: src/word_acc.sv
`timescale 1ns/10ps
`include "redc_consts.svh"

module word_acc (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 clear,
	input  logic                 add_en,
	input  redc_data_pkg::prod_t prod,
	output redc_data_pkg::word_t word,
	output logic                 word_ready
);

	localparam int ACC_W = 130;  // product plus carried-down high part

	logic [ACC_W-1:0] acc;
	logic [ACC_W-1:0] acc_next;

	// next column: carry down one word, add the new product
	assign acc_next = (acc >> `REDC_WORD_W) + {2'b00, prod};

	always_ff @(posedge clk) begin
		if (rst || clear) begin
			acc <= '0;
		end else if (add_en) begin
			acc <= acc_next;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			word_ready <= 1'b0;
		end else begin
			word_ready <= add_en;
		end
	end

	assign word = acc[`REDC_WORD_W-1:0];  // low word of the current column

endmodule

// File: tb/barrett_redc_chk.sv
`timescale 1ns/10ps
`include "redc_consts.svh"

module barrett_redc_chk (
	input logic                   clk,
	input logic                   rst,
	input logic                   loaded,
	input redc_data_pkg::res_wr_t res,
	input logic                   red_done,
	input logic                   burst_done
);

	int   fail_cnt = 0;
	logic seen_load;

	always_ff @(posedge clk) begin
		if (rst) begin
			seen_load <= 1'b0;
		end else if (loaded) begin
			seen_load <= 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// output protocol
	//////////////////////////////////////////////////

	quiet_before_load: assert property (@(posedge clk) disable iff (rst)
		!seen_load |-> !res.we && !red_done && !burst_done)
		else begin
			$error("result port active before any operand was loaded");
			fail_cnt++;
		end

	// four writes in a row, then done
	done_after_writes: assert property (@(posedge clk) disable iff (rst)
		red_done |-> !res.we && $past(res.we, 1) && $past(res.we, 2)
			&& $past(res.we, 3) && $past(res.we, 4) && !$past(res.we, 5))
		else begin
			$error("red_done not preceded by exactly four consecutive writes");
			fail_cnt++;
		end

	writes_then_done: assert property (@(posedge clk) disable iff (rst)
		!res.we && $past(res.we) |-> red_done)
		else begin
			$error("red_done missing one cycle after the last write");
			fail_cnt++;
		end

	// top result word is bounded by the top modulus word
	top_word_range: assert property (@(posedge clk) disable iff (rst)
		res.we && (res.addr == `REDC_BASE_LO + 11'd3 || res.addr == `REDC_BASE_HI + 11'd3)
		|-> res.data <= `REDC_Q_W3)
		else begin
			$error("top result word exceeds the top modulus word");
			fail_cnt++;
		end

endmodule

bind barrett_redc_top barrett_redc_chk u_chk (
	.clk        (clk),
	.rst        (rst),
	.loaded     (loaded),
	.res        (res),
	.red_done   (red_done),
	.burst_done (burst_done)
);

// File: tb/tb_barrett_redc.sv
`timescale 1ns/10ps
`include "redc_consts.svh"

module tb_barrett_redc;

	localparam int W       = `REDC_WORD_W;
	localparam int TIMEOUT = 2000;  // cycles per reduction

	logic                    clk;
	logic                    rst;
	logic                    in_valid;
	redc_data_pkg::op_pair_t in_pair;
	logic                    sign_strobe;
	logic                    sign_in;
	redc_data_pkg::res_wr_t  res;
	logic                    red_done;
	logic                    burst_done;

	logic [255:0] q_ref;
	logic [255:0] all_ones;
	int           errors;
	int           tests_run;
	int           tests_failed;
	int           red_idx;    // reductions since reset, picks base and core

	barrett_redc_top u_barrett_redc_top (
		.clk         (clk),
		.rst         (rst),
		.in_valid    (in_valid),
		.in_pair     (in_pair),
		.sign_strobe (sign_strobe),
		.sign_in     (sign_in),
		.res         (res),
		.red_done    (red_done),
		.burst_done  (burst_done)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic compare_field(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp) else begin
			$display("error %0t %s got %0h expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	function automatic logic [255:0] random_operand();
		logic [255:0] v;
		for (int i = 0; i < 8; i++) begin
			v[i*32 +: 32] = $urandom;
		end
		return v & all_ones;
	endfunction

	// two loads, the gap lets the controller return to its wait state
	task automatic load_operand(input logic [255:0] x);
		for (int p = 0; p < 2; p++) begin
			@(posedge clk);
			in_valid   <= 1'b1;
			in_pair.lo <= x[(2*p)*W +: W];
			in_pair.hi <= x[(2*p+1)*W +: W];
			@(posedge clk);
			in_valid <= 1'b0;
			if (p == 0) repeat (3) @(posedge clk);
		end
	endtask

	//////////////////////////////////////////////////
	// one reduction with its expected write burst
	//////////////////////////////////////////////////

	task automatic run_reduction(input string name, input logic [255:0] x, input logic sgn);
		redc_data_pkg::res_wr_t got [4];
		logic [255:0]           exp_r;
		logic [10:0]            base;
		logic [2:0]             core;
		int                     n_wr;
		int                     err_before;
		bit                     finished;
		err_before = errors;
		exp_r      = x % q_ref;
		base       = (red_idx % 4 < 2) ? `REDC_BASE_LO : `REDC_BASE_HI;
		core       = (red_idx % 2 == 1) ? `REDC_CORE_ODD : `REDC_CORE_EVEN;
		n_wr       = 0;
		finished   = 1'b0;
		@(posedge clk);
		sign_strobe <= 1'b1;
		sign_in     <= sgn;
		@(posedge clk);
		sign_strobe <= 1'b0;
		load_operand(x);
		for (int t = 0; t < TIMEOUT && !finished; t++) begin
			@(posedge clk);
			if (res.we) begin
				if (n_wr < 4) got[n_wr] = res;
				n_wr++;
			end
			// burst_done only beside the fourth red_done of a burst
			compare_field("burst_done", burst_done, red_done && red_idx % 4 == 3);
			if (red_done) begin
				finished = 1'b1;
			end
		end
		if (!finished) begin
			$display("timeout: no red_done within %0d cycles in test %s", TIMEOUT, name);
			errors++;
		end else if (n_wr != 4) begin
			$display("test %s produced %0d result writes instead of 4", name, n_wr);
			errors++;
		end else begin
			for (int k = 0; k < 4; k++) begin
				compare_field($sformatf("res.data[%0d]", k), got[k].data, exp_r[k*W +: W]);
				compare_field($sformatf("res.addr[%0d]", k), got[k].addr, base + k);
				compare_field($sformatf("res.core[%0d]", k), got[k].core, core);
				compare_field($sformatf("res.sign[%0d]", k), got[k].sign, sgn);
			end
		end
		red_idx++;
		tests_run++;
		if (errors != err_before) tests_failed++;
		$display("test %-10s %s", name, (errors == err_before) ? "ok" : "failed");
	endtask

	initial begin
		logic [255:0] x;
		void'($urandom(32'h9c0a_fc77));
		rst          = 1'b1;
		in_valid     = 1'b0;
		in_pair      = '0;
		sign_strobe  = 1'b0;
		sign_in      = 1'b0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		red_idx      = 0;
		q_ref        = {`REDC_Q_W3, `REDC_Q_W2, `REDC_Q_W1, `REDC_Q_W0};
		all_ones     = (256'd1 << (`REDC_OP_WORDS * W)) - 256'd1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		run_reduction("zero", '0, 1'b0);
		run_reduction("below_q", q_ref - 256'd1, 1'b1);
		run_reduction("equal_q", q_ref, 1'b0);
		run_reduction("twice_q", q_ref << 1, 1'b1);
		run_reduction("all_ones", all_ones, 1'b1);
		for (int i = 0; i < 2; i++) begin
			x = random_operand() & ((256'd1 << 150) - 256'd1);  // well below q
			run_reduction($sformatf("small_%0d", i), x, 1'(i));
		end
		for (int i = 0; i < 8; i++) begin
			x = random_operand();
			run_reduction($sformatf("rand_%0d", i), x, 1'($urandom));
		end

		repeat (2) @(posedge clk);
		$display("tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
			tests_run, tests_failed, errors, u_barrett_redc_top.u_chk.fail_cnt);
		if (errors == 0 && u_barrett_redc_top.u_chk.fail_cnt == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule
